// File: Bender.yml
package:
  name: pipeline_controller

sources:
  - files:
      - rtl/isa_pkg.sv
      - rtl/ctrl_pkg.sv
      - rtl/pipe_stage.sv
      - rtl/hazard_unit.sv
      - rtl/execute_ctrl.sv
      - rtl/memory_ctrl.sv
      - rtl/writeback_ctrl.sv
      - rtl/pipeline_controller.sv
  - target: simulation
    files:
      - sim/tb_pipeline_controller.sv

// File: rtl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // operand source for the execute-stage latches
    typedef enum logic [1:0] {
        fwd_none = 2'b00,
        fwd_mem  = 2'b01,
        fwd_wb   = 2'b10
    } fwd_sel_t;

    // next pc source
    typedef enum logic [1:0] {
        pc_inc    = 2'b00,
        pc_reset  = 2'b01,
        pc_branch = 2'b10
    } pc_sel_t;

    // register file write port 1 address
    typedef enum logic [1:0] {
        waddr_rd   = 2'b00,
        waddr_rn   = 2'b01,
        waddr_none = 2'b11
    } waddr_sel_t;

endpackage

`default_nettype wire

// File: rtl/execute_ctrl.sv
`default_nettype none

module execute_ctrl import isa_pkg::*; import ctrl_pkg::*; #(
    parameter int PC_W = 7
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            dec_valid,
    input  instr_t          dec_instr,
    input  logic [PC_W-1:0] dec_pc,
    input  logic            dec_epoch,
    input  logic            epoch,
    input  logic [3:0]      mem_dest,
    input  logic            mem_we,
    input  logic            mem_is_load,
    input  logic [3:0]      wait_dest,
    input  logic            wait_is_load,
    input  logic [3:0]      wb_dest,
    input  logic            wb_we,
    output logic [6:0]      opcode,
    output logic [3:0]      rn,
    output logic [3:0]      rm,
    output logic [3:0]      rs,
    output logic [4:0]      imm5,
    output logic [PC_W-1:0] ex_pc,
    output fwd_sel_t        sel_a_in,
    output fwd_sel_t        sel_b_in,
    output fwd_sel_t        sel_shift_in,
    output logic            sel_shift,
    output logic            en_a,
    output logic            en_b,
    output logic            en_s,
    output logic            stall,
    output logic            ex_valid_out,
    output instr_t          ex_instr_out,
    output logic            ex_epoch_out
);

    logic      valid_q;
    op_class_t op_class;
    logic      uses_rn;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_instr_out <= dec_instr;
            ex_pc        <= dec_pc;
            ex_epoch_out <= dec_epoch;
        end
    end

    // squashed once a branch has flipped the epoch
    assign ex_valid_out = valid_q && (ex_epoch_out == epoch);

    assign opcode = ex_instr_out[OPCODE_LSB +: 7];
    assign rn     = ex_instr_out[RN_LSB +: 4];
    assign rm     = ex_instr_out[RM_LSB +: 4];
    assign rs     = ex_instr_out[RS_LSB +: 4];
    assign imm5   = ex_instr_out[IMM5_LSB +: 5];

    assign op_class  = op_class_t'(opcode[6:4]);
    assign sel_shift = (op_class == op_alu_reg) && opcode[OPC_MOD_BIT];
    assign uses_rn   = op_class inside {op_alu_reg, op_alu_imm, op_ldr, op_str};

    assign en_a = ex_valid_out && !stall;
    assign en_b = ex_valid_out && !stall;
    assign en_s = ex_valid_out && !stall;

    hazard_unit u_hazard (
        .ex_valid     (ex_valid_out && uses_rn),
        .ex_rn        (rn),
        .ex_rm        (rm),
        .ex_rs        (rs),
        .ex_uses_rm   (op_class == op_alu_reg),
        .ex_uses_rs   (sel_shift),
        .mem_dest     (mem_dest),
        .mem_we       (mem_we),
        .mem_is_load  (mem_is_load),
        .wait_dest    (wait_dest),
        .wait_is_load (wait_is_load),
        .wb_dest      (wb_dest),
        .wb_we        (wb_we),
        .sel_a_in     (sel_a_in),
        .sel_b_in     (sel_b_in),
        .sel_shift_in (sel_shift_in),
        .stall        (stall)
    );

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
`default_nettype none

module hazard_unit import ctrl_pkg::*; (
    input  logic       ex_valid,
    input  logic [3:0] ex_rn,
    input  logic [3:0] ex_rm,
    input  logic [3:0] ex_rs,
    input  logic       ex_uses_rm,
    input  logic       ex_uses_rs,
    input  logic [3:0] mem_dest,
    input  logic       mem_we,
    input  logic       mem_is_load,
    input  logic [3:0] wait_dest,
    input  logic       wait_is_load,
    input  logic [3:0] wb_dest,
    input  logic       wb_we,
    output fwd_sel_t   sel_a_in,
    output fwd_sel_t   sel_b_in,
    output fwd_sel_t   sel_shift_in,
    output logic       stall
);

    logic stall_rn;
    logic stall_rm;
    logic stall_rs;

    // memory stage wins, it holds the younger result
    function automatic fwd_sel_t pick(input logic [3:0] src, input logic [3:0] m_dest,
                                      input logic m_we, input logic m_load,
                                      input logic [3:0] w_dest, input logic w_we);
        fwd_sel_t sel;
        sel = fwd_none;
        if (m_we && !m_load && m_dest == src) begin
            sel = fwd_mem;
        end else if (w_we && w_dest == src) begin
            sel = fwd_wb;
        end
        return sel;
    endfunction

    // load data not available yet in memory or memory-wait
    function automatic logic load_hit(input logic [3:0] src, input logic [3:0] m_dest,
                                      input logic m_load, input logic [3:0] q_dest,
                                      input logic q_load);
        return (m_load && m_dest == src) || (q_load && q_dest == src);
    endfunction

    assign sel_a_in     = pick(ex_rn, mem_dest, mem_we, mem_is_load, wb_dest, wb_we);
    assign sel_b_in     = pick(ex_rm, mem_dest, mem_we, mem_is_load, wb_dest, wb_we);
    assign sel_shift_in = pick(ex_rs, mem_dest, mem_we, mem_is_load, wb_dest, wb_we);

    assign stall_rn = load_hit(ex_rn, mem_dest, mem_is_load, wait_dest, wait_is_load);
    assign stall_rm = ex_uses_rm
                      && load_hit(ex_rm, mem_dest, mem_is_load, wait_dest, wait_is_load);
    assign stall_rs = ex_uses_rs
                      && load_hit(ex_rs, mem_dest, mem_is_load, wait_dest, wait_is_load);

    assign stall = ex_valid && (stall_rn || stall_rm || stall_rs);

endmodule

`default_nettype wire

// File: rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [31:0] instr_t;

    // lsb of each field within instr_t
    localparam int COND_LSB     = 28;
    localparam int OPCODE_LSB   = 21;
    localparam int RN_LSB       = 16;
    localparam int RD_LSB       = 12;
    localparam int RS_LSB       = 8;
    localparam int IMM5_LSB     = 7;
    localparam int SHIFT_OP_LSB = 5;
    localparam int RM_LSB       = 0;

    // instruction class, upper three opcode bits
    typedef enum logic [2:0] {
        op_alu_reg = 3'b000,
        op_alu_imm = 3'b001,
        op_ldr     = 3'b010,
        op_str     = 3'b011,
        op_b       = 3'b100,
        op_nop     = 3'b111
    } op_class_t;

    // alu operation, lower three opcode bits
    localparam logic [2:0] ALU_ADD = 3'b000;
    localparam logic [2:0] ALU_CMP = 3'b111;

    // register-specified shift for alu_reg, pre-indexed for ldr/str
    localparam int OPC_MOD_BIT = 3;
    // base write-back on a store
    localparam int OPC_WB_BIT  = 0;

    // codes 4'hf and up count as never
    typedef enum logic [3:0] {
        cond_eq, cond_ne, cond_cs, cond_cc, cond_mi, cond_pl, cond_vs, cond_vc,
        cond_hi, cond_ls, cond_ge, cond_lt, cond_gt, cond_le, cond_al
    } cond_t;

    localparam int FLAG_N = 31;
    localparam int FLAG_Z = 30;
    localparam int FLAG_C = 29;
    localparam int FLAG_V = 28;

endpackage

`default_nettype wire

// File: rtl/memory_ctrl.sv
`default_nettype none

module memory_ctrl import isa_pkg::*; import ctrl_pkg::*; #(
    parameter int PC_W = 7
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ex_valid,
    input  instr_t          ex_instr,
    input  logic [PC_W-1:0] ex_pc,
    input  logic            ex_epoch,
    input  logic            stall,
    input  logic            epoch,
    input  logic [31:0]     status,
    output logic [3:0]      cond,
    output logic [6:0]      opcode,
    output logic [3:0]      rn,
    output logic [3:0]      rd,
    output logic [1:0]      shift_op,
    output logic [11:0]     imm12,
    output logic [31:0]     imm_branch,
    output logic [PC_W-1:0] mem_pc,
    output pc_sel_t         sel_pc,
    output logic            sel_branch_imm,
    output logic            sel_a,
    output logic            sel_b,
    output logic [2:0]      alu_op,
    output logic            sel_pre_indexed,
    output logic            en_status,
    output waddr_sel_t      sel_w_addr1,
    output logic            w_en1,
    output logic            mem_w_en,
    output logic            branch_taken,
    output logic [3:0]      mem_dest,
    output logic            mem_we,
    output logic            mem_is_load
);

    logic      valid_q;
    logic      epoch_q;
    instr_t    instr_q;
    logic      mem_valid;
    op_class_t op_class;
    logic      is_alu;
    logic      is_cmp;
    logic      cond_pass;
    logic      go;
    logic      n;
    logic      z;
    logic      c;
    logic      v;

    // a stalled execute stage sends a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= ex_valid && !stall;
        end
    end

    always_ff @(posedge clk) begin
        instr_q <= ex_instr;
        mem_pc  <= ex_pc;
        epoch_q <= ex_epoch;
    end

    assign mem_valid = valid_q && (epoch_q == epoch);

    assign cond       = instr_q[COND_LSB +: 4];
    assign opcode     = instr_q[OPCODE_LSB +: 7];
    assign rn         = instr_q[RN_LSB +: 4];
    assign rd         = instr_q[RD_LSB +: 4];
    assign shift_op   = instr_q[SHIFT_OP_LSB +: 2];
    assign imm12      = instr_q[11:0];
    assign imm_branch = {{8{instr_q[23]}}, instr_q[23:0]};

    assign n = status[FLAG_N];
    assign z = status[FLAG_Z];
    assign c = status[FLAG_C];
    assign v = status[FLAG_V];

    always_comb begin
        case (cond_t'(cond))
            cond_eq: cond_pass = z;
            cond_ne: cond_pass = !z;
            cond_cs: cond_pass = c;
            cond_cc: cond_pass = !c;
            cond_mi: cond_pass = n;
            cond_pl: cond_pass = !n;
            cond_vs: cond_pass = v;
            cond_vc: cond_pass = !v;
            cond_hi: cond_pass = c && !z;
            cond_ls: cond_pass = !c || z;
            cond_ge: cond_pass = (n == v);
            cond_lt: cond_pass = (n != v);
            cond_gt: cond_pass = !z && (n == v);
            cond_le: cond_pass = z || (n != v);
            cond_al: cond_pass = 1'b1;
            default: cond_pass = 1'b0;
        endcase
    end

    assign go       = mem_valid && cond_pass;
    assign op_class = op_class_t'(opcode[6:4]);
    assign is_alu   = op_class inside {op_alu_reg, op_alu_imm};
    assign is_cmp   = is_alu && (opcode[2:0] == ALU_CMP);

    // pc as operand a and the immediate as operand b for branch targets
    assign sel_branch_imm  = (op_class == op_b);
    assign sel_a           = (op_class == op_b);
    assign sel_b           = (op_class != op_alu_reg);
    assign alu_op          = is_alu ? opcode[2:0] : ALU_ADD;
    assign sel_pre_indexed = (op_class inside {op_ldr, op_str}) && opcode[OPC_MOD_BIT];

    always_comb begin
        if (is_alu && !is_cmp) begin
            sel_w_addr1 = waddr_rd;
        end else if (op_class == op_str && opcode[OPC_WB_BIT]) begin
            sel_w_addr1 = waddr_rn;
        end else begin
            sel_w_addr1 = waddr_none;
        end
    end

    assign en_status    = go && is_cmp;
    assign w_en1        = go && (sel_w_addr1 != waddr_none);
    assign mem_w_en     = go && (op_class == op_str);
    assign branch_taken = go && (op_class == op_b);
    assign sel_pc       = branch_taken ? pc_branch : pc_inc;

    // destination seen by the hazard unit
    assign mem_dest    = (sel_w_addr1 == waddr_rn) ? rn : rd;
    assign mem_we      = w_en1;
    assign mem_is_load = go && (op_class == op_ldr);

    // the global epoch flips behind every taken branch
    a_branch_epoch: assert property (
        @(posedge clk) disable iff (!rst_n) branch_taken |=> (epoch != $past(epoch))
    );

endmodule

`default_nettype wire

// File: rtl/pipe_stage.sv
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold,
    input  logic     bubble,
    input  logic     valid_in,
    input  payload_t payload_in,
    output logic     valid_out,
    output payload_t payload_out
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else if (!hold) begin
            valid_out <= valid_in && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            payload_out <= payload_in;
        end
    end

    // a held stage cannot be flushed in the same cycle
    a_hold_bubble: assert property (
        @(posedge clk) disable iff (!rst_n) !(hold && bubble)
    );

endmodule

`default_nettype wire

// File: rtl/pipeline_controller.sv
`default_nettype none

module pipeline_controller import isa_pkg::*; import ctrl_pkg::*; #(
    parameter int PC_W = 7
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  instr_t          instr,
    input  logic [PC_W-1:0] pc,
    input  logic [31:0]     status,
    output logic            instr_ready,
    // execute stage
    output logic [6:0]      ex_opcode,
    output logic [3:0]      ex_rn,
    output logic [3:0]      ex_rm,
    output logic [3:0]      ex_rs,
    output logic [4:0]      ex_imm5,
    output logic [PC_W-1:0] ex_pc,
    output fwd_sel_t        sel_a_in,
    output fwd_sel_t        sel_b_in,
    output fwd_sel_t        sel_shift_in,
    output logic            sel_shift,
    output logic            en_a,
    output logic            en_b,
    output logic            en_s,
    // memory stage
    output logic [3:0]      mem_cond,
    output logic [6:0]      mem_opcode,
    output logic [3:0]      mem_rn,
    output logic [3:0]      mem_rd,
    output logic [1:0]      mem_shift_op,
    output logic [11:0]     mem_imm12,
    output logic [31:0]     mem_imm_branch,
    output logic [PC_W-1:0] mem_pc,
    output pc_sel_t         sel_pc,
    output logic            sel_branch_imm,
    output logic            sel_a,
    output logic            sel_b,
    output logic [2:0]      alu_op,
    output logic            sel_pre_indexed,
    output logic            en_status,
    output waddr_sel_t      sel_w_addr1,
    output logic            w_en1,
    output logic            mem_w_en,
    output logic            branch_taken,
    // load write-back
    output logic            w_en_ldr,
    output logic [3:0]      wb_rt
);

    typedef struct packed {
        instr_t          instr;
        logic [PC_W-1:0] pc;
        logic            epoch;
    } dec_t;

    logic       start_q;
    logic       epoch_q;
    logic       stall;
    dec_t       fetch_p;
    dec_t       dec_p;
    logic       dec_valid;
    logic       ex_valid;
    instr_t     ex_instr;
    logic       ex_epoch;
    pc_sel_t    mem_sel_pc;
    logic [3:0] mem_dest;
    logic       mem_we;
    logic       mem_is_load;
    logic [3:0] wait_dest;
    logic       wait_is_load;

    // one start-up cycle to load the reset vector
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q <= 1'b1;
            epoch_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (branch_taken) begin
                epoch_q <= !epoch_q;
            end
        end
    end

    assign instr_ready = !start_q && !stall;
    assign sel_pc      = start_q ? pc_reset : mem_sel_pc;
    assign fetch_p     = '{instr: instr, pc: pc, epoch: epoch_q};

    // decode register
    pipe_stage #(.payload_t(dec_t)) u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .hold        (stall),
        .bubble      (branch_taken && !stall),
        .valid_in    (instr_valid && instr_ready),
        .payload_in  (fetch_p),
        .valid_out   (dec_valid),
        .payload_out (dec_p)
    );

    execute_ctrl #(.PC_W(PC_W)) u_execute (
        .clk (clk), .rst_n (rst_n),
        .dec_valid (dec_valid), .dec_instr (dec_p.instr),
        .dec_pc (dec_p.pc), .dec_epoch (dec_p.epoch), .epoch (epoch_q),
        .mem_dest (mem_dest), .mem_we (mem_we), .mem_is_load (mem_is_load),
        .wait_dest (wait_dest), .wait_is_load (wait_is_load),
        .wb_dest (wb_rt), .wb_we (w_en_ldr),
        .opcode (ex_opcode), .rn (ex_rn), .rm (ex_rm), .rs (ex_rs), .imm5 (ex_imm5),
        .ex_pc (ex_pc),
        .sel_a_in (sel_a_in), .sel_b_in (sel_b_in), .sel_shift_in (sel_shift_in),
        .sel_shift (sel_shift), .en_a (en_a), .en_b (en_b), .en_s (en_s),
        .stall (stall),
        .ex_valid_out (ex_valid), .ex_instr_out (ex_instr), .ex_epoch_out (ex_epoch)
    );

    memory_ctrl #(.PC_W(PC_W)) u_memory (
        .clk (clk), .rst_n (rst_n),
        .ex_valid (ex_valid), .ex_instr (ex_instr), .ex_pc (ex_pc), .ex_epoch (ex_epoch),
        .stall (stall), .epoch (epoch_q), .status (status),
        .cond (mem_cond), .opcode (mem_opcode), .rn (mem_rn), .rd (mem_rd),
        .shift_op (mem_shift_op), .imm12 (mem_imm12), .imm_branch (mem_imm_branch),
        .mem_pc (mem_pc), .sel_pc (mem_sel_pc), .sel_branch_imm (sel_branch_imm),
        .sel_a (sel_a), .sel_b (sel_b), .alu_op (alu_op),
        .sel_pre_indexed (sel_pre_indexed), .en_status (en_status),
        .sel_w_addr1 (sel_w_addr1), .w_en1 (w_en1), .mem_w_en (mem_w_en),
        .branch_taken (branch_taken),
        .mem_dest (mem_dest), .mem_we (mem_we), .mem_is_load (mem_is_load)
    );

    // any register writer leaving memory is tracked
    writeback_ctrl u_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_valid    (mem_we || mem_is_load),
        .mem_dest     (mem_dest),
        .mem_is_load  (mem_is_load),
        .wait_dest    (wait_dest),
        .wait_is_load (wait_is_load),
        .w_en_ldr     (w_en_ldr),
        .wb_rt        (wb_rt)
    );

    // the instruction behind a taken branch is always squashed
    a_no_back_to_back: assert property (
        @(posedge clk) disable iff (!rst_n) branch_taken |=> !branch_taken
    );

endmodule

`default_nettype wire

// File: rtl/writeback_ctrl.sv
`default_nettype none

module writeback_ctrl (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       mem_valid,
    input  logic [3:0] mem_dest,
    input  logic       mem_is_load,
    output logic [3:0] wait_dest,
    output logic       wait_is_load,
    output logic       w_en_ldr,
    output logic [3:0] wb_rt
);

    typedef struct packed {
        logic [3:0] dest;
        logic       is_load;
    } dst_t;

    dst_t mem_p;
    dst_t wait_p;
    dst_t wb_p;
    logic wait_valid;
    logic wb_valid;

    assign mem_p = '{dest: mem_dest, is_load: mem_is_load};

    // memory-wait stage
    pipe_stage #(.payload_t(dst_t)) u_wait (
        .clk         (clk),
        .rst_n       (rst_n),
        .hold        (1'b0),
        .bubble      (1'b0),
        .valid_in    (mem_valid),
        .payload_in  (mem_p),
        .valid_out   (wait_valid),
        .payload_out (wait_p)
    );

    // load write-back stage
    pipe_stage #(.payload_t(dst_t)) u_wb (
        .clk         (clk),
        .rst_n       (rst_n),
        .hold        (1'b0),
        .bubble      (1'b0),
        .valid_in    (wait_valid),
        .payload_in  (wait_p),
        .valid_out   (wb_valid),
        .payload_out (wb_p)
    );

    assign wait_dest    = wait_p.dest;
    assign wait_is_load = wait_valid && wait_p.is_load;
    assign w_en_ldr     = wb_valid && wb_p.is_load;
    assign wb_rt        = wb_p.dest;

endmodule

`default_nettype wire

// File: sim.f
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/pipe_stage.sv
rtl/hazard_unit.sv
rtl/execute_ctrl.sv
rtl/memory_ctrl.sv
rtl/writeback_ctrl.sv
rtl/pipeline_controller.sv
sim/tb_pipeline_controller.sv

// File: sim/tb_pipeline_controller.sv
`default_nettype none

module tb_pipeline_controller import isa_pkg::*, ctrl_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PC_W        = 7;
    localparam int N_CYCLES    = 3000;
    localparam int DRAIN_LIMIT = 40;

    logic            clk;
    logic            rst_n;
    logic            instr_valid;
    logic [31:0]     instr;
    logic [PC_W-1:0] pc;
    logic [31:0]     status;
    logic            instr_ready;
    logic [6:0]      ex_opcode;
    logic [3:0]      ex_rn, ex_rm, ex_rs;
    logic [4:0]      ex_imm5;
    logic [PC_W-1:0] ex_pc;
    logic [1:0]      sel_a_in, sel_b_in, sel_shift_in;
    logic            sel_shift, en_a, en_b, en_s;
    logic [3:0]      mem_cond;
    logic [6:0]      mem_opcode;
    logic [3:0]      mem_rn, mem_rd;
    logic [1:0]      mem_shift_op;
    logic [11:0]     mem_imm12;
    logic [31:0]     mem_imm_branch;
    logic [PC_W-1:0] mem_pc;
    logic [1:0]      sel_pc, sel_w_addr1;
    logic            sel_branch_imm, sel_a, sel_b, sel_pre_indexed;
    logic [2:0]      alu_op;
    logic            en_status, w_en1, mem_w_en, branch_taken;
    logic            w_en_ldr;
    logic [3:0]      wb_rt;

    // reference pipeline state
    logic            m_start, m_epoch;
    logic            m_dec_v, m_dec_e, m_ex_v, m_ex_e, m_mem_v, m_mem_e;
    logic [31:0]     m_dec_i, m_ex_i, m_mem_i;
    logic [PC_W-1:0] m_dec_pc, m_ex_pc, m_mem_pc;
    logic            m_wait_v, m_wait_l, m_wb_v, m_wb_l;
    logic [3:0]      m_wait_d, m_wb_d;
    // values the model expects between two edges
    logic            x_valid, mm_valid, x_go, x_stall, x_ready;
    logic            x_btaken, x_we, x_load, x_status_en, x_store;
    logic [3:0]      x_dest;

    logic [31:0]     lfsr;
    logic [PC_W-1:0] next_pc;
    int              n_checks, n_errors, n_accept, n_stall, n_branch, n_load;
    int              waited;

    pipeline_controller #(.PC_W(PC_W)) uut (
        .clk (clk), .rst_n (rst_n),
        .instr_valid (instr_valid), .instr (instr), .pc (pc), .status (status),
        .instr_ready (instr_ready),
        .ex_opcode (ex_opcode), .ex_rn (ex_rn), .ex_rm (ex_rm), .ex_rs (ex_rs),
        .ex_imm5 (ex_imm5), .ex_pc (ex_pc),
        .sel_a_in (sel_a_in), .sel_b_in (sel_b_in), .sel_shift_in (sel_shift_in),
        .sel_shift (sel_shift), .en_a (en_a), .en_b (en_b), .en_s (en_s),
        .mem_cond (mem_cond), .mem_opcode (mem_opcode), .mem_rn (mem_rn), .mem_rd (mem_rd),
        .mem_shift_op (mem_shift_op), .mem_imm12 (mem_imm12),
        .mem_imm_branch (mem_imm_branch), .mem_pc (mem_pc),
        .sel_pc (sel_pc), .sel_branch_imm (sel_branch_imm), .sel_a (sel_a), .sel_b (sel_b),
        .alu_op (alu_op), .sel_pre_indexed (sel_pre_indexed), .en_status (en_status),
        .sel_w_addr1 (sel_w_addr1), .w_en1 (w_en1), .mem_w_en (mem_w_en),
        .branch_taken (branch_taken), .w_en_ldr (w_en_ldr), .wb_rt (wb_rt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // right-shift galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // low registers more often so that hazards show up
    function automatic logic [3:0] pick_reg();
        if (take_bits(1) == 1) begin
            return take_bits(2);
        end
        return take_bits(4);
    endfunction

    function automatic logic [31:0] make_instr();
        logic [31:0] w;
        logic [2:0]  cls;
        w = take_bits(32);
        case (take_bits(3))
            0, 1:    cls = op_alu_reg;
            2:       cls = op_alu_imm;
            3, 6:    cls = op_ldr;
            4:       cls = op_str;
            5:       cls = op_b;
            default: cls = op_nop;
        endcase
        w[27:25] = cls;
        // mostly always, otherwise any code including never
        if (take_bits(2) != 0) begin
            w[31:28] = 4'he;
        end
        w[19:16] = pick_reg();
        w[15:12] = pick_reg();
        w[11:8]  = pick_reg();
        w[3:0]   = pick_reg();
        return w;
    endfunction

    function automatic logic cond_ok(input logic [3:0] cc, input logic [31:0] st);
        logic n, z, c, v;
        n = st[FLAG_N];
        z = st[FLAG_Z];
        c = st[FLAG_C];
        v = st[FLAG_V];
        case (cc)
            4'h0: return z;
            4'h1: return !z;
            4'h2: return c;
            4'h3: return !c;
            4'h4: return n;
            4'h5: return !n;
            4'h6: return v;
            4'h7: return !v;
            4'h8: return c && !z;
            4'h9: return !c || z;
            4'ha: return n == v;
            4'hb: return n != v;
            4'hc: return !z && (n == v);
            4'hd: return z || (n != v);
            4'he: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // load result not yet available to execute
    function automatic logic load_pending(input logic [3:0] r);
        return (x_load && x_dest == r) || (m_wait_v && m_wait_l && m_wait_d == r);
    endfunction

    function automatic logic [1:0] fwd_expect(input logic [3:0] r);
        if (x_we && x_dest == r) begin
            return fwd_mem;
        end
        if (m_wb_v && m_wb_l && m_wb_d == r) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic eval_model();
        logic [2:0] xc, mc;
        logic       is_alu, is_cmp, base_wb, rd_rn, rd_rm, rd_rs;
        xc          = m_ex_i[27:25];
        mc          = m_mem_i[27:25];
        x_valid     = m_ex_v && (m_ex_e == m_epoch);
        mm_valid    = m_mem_v && (m_mem_e == m_epoch);
        x_go        = mm_valid && cond_ok(m_mem_i[31:28], status);
        is_alu      = (mc == op_alu_reg) || (mc == op_alu_imm);
        is_cmp      = is_alu && (m_mem_i[23:21] == 3'b111);
        base_wb     = (mc == op_str) && m_mem_i[21];
        x_status_en = x_go && is_cmp;
        x_store     = x_go && (mc == op_str);
        x_btaken    = x_go && (mc == op_b);
        x_load      = x_go && (mc == op_ldr);
        x_we        = x_go && ((is_alu && !is_cmp) || base_wb);
        x_dest      = base_wb ? m_mem_i[19:16] : m_mem_i[15:12];
        rd_rn       = xc inside {op_alu_reg, op_alu_imm, op_ldr, op_str};
        rd_rm       = (xc == op_alu_reg);
        rd_rs       = rd_rm && m_ex_i[24];
        x_stall     = x_valid && ((rd_rn && load_pending(m_ex_i[19:16]))
                      || (rd_rm && load_pending(m_ex_i[3:0]))
                      || (rd_rs && load_pending(m_ex_i[11:8])));
        x_ready     = !m_start && !x_stall;
    endtask

    task automatic compare_outputs();
        logic [2:0] mc;
        logic       mem_alu;
        logic [1:0] waddr_exp;
        mc      = m_mem_i[27:25];
        mem_alu = (mc == op_alu_reg) || (mc == op_alu_imm);
        // alu results go to rd, a store with base write-back goes to rn
        if (mem_alu && m_mem_i[23:21] != 3'b111) begin
            waddr_exp = waddr_rd;
        end else if (mc == op_str && m_mem_i[21]) begin
            waddr_exp = waddr_rn;
        end else begin
            waddr_exp = waddr_none;
        end
        check("instr_ready", instr_ready, x_ready);
        check("sel_pc", sel_pc, m_start ? pc_reset : (x_btaken ? pc_branch : pc_inc));
        check("en_a", en_a, x_valid && !x_stall);
        check("en_b", en_b, x_valid && !x_stall);
        check("en_s", en_s, x_valid && !x_stall);
        check("en_status", en_status, x_status_en);
        check("w_en1", w_en1, x_we);
        check("mem_w_en", mem_w_en, x_store);
        check("branch_taken", branch_taken, x_btaken);
        check("w_en_ldr", w_en_ldr, m_wb_v && m_wb_l);
        if (m_wb_v && m_wb_l) begin
            n_load++;
            check("wb_rt", wb_rt, m_wb_d);
        end
        if (x_valid) begin
            check("ex_opcode", ex_opcode, m_ex_i[27:21]);
            check("ex_rn", ex_rn, m_ex_i[19:16]);
            check("ex_rm", ex_rm, m_ex_i[3:0]);
            check("ex_rs", ex_rs, m_ex_i[11:8]);
            check("ex_imm5", ex_imm5, m_ex_i[11:7]);
            check("ex_pc", ex_pc, m_ex_pc);
            check("sel_shift", sel_shift, (m_ex_i[27:25] == op_alu_reg) && m_ex_i[24]);
            check("sel_a_in", sel_a_in, fwd_expect(m_ex_i[19:16]));
            check("sel_b_in", sel_b_in, fwd_expect(m_ex_i[3:0]));
            check("sel_shift_in", sel_shift_in, fwd_expect(m_ex_i[11:8]));
        end
        if (mm_valid) begin
            check("mem_cond", mem_cond, m_mem_i[31:28]);
            check("mem_opcode", mem_opcode, m_mem_i[27:21]);
            check("mem_rn", mem_rn, m_mem_i[19:16]);
            check("mem_rd", mem_rd, m_mem_i[15:12]);
            check("mem_shift_op", mem_shift_op, m_mem_i[6:5]);
            check("mem_imm12", mem_imm12, m_mem_i[11:0]);
            check("mem_imm_branch", mem_imm_branch,
                  (m_mem_i[23] ? 32'hff00_0000 : 32'h0) | m_mem_i[23:0]);
            check("mem_pc", mem_pc, m_mem_pc);
            check("sel_branch_imm", sel_branch_imm, mc == op_b);
            check("sel_a", sel_a, mc == op_b);
            check("sel_b", sel_b, mc != op_alu_reg);
            check("alu_op", alu_op, mem_alu ? m_mem_i[23:21] : 3'b000);
            check("sel_pre_indexed", sel_pre_indexed,
                  (mc == op_ldr || mc == op_str) && m_mem_i[24]);
            check("sel_w_addr1", sel_w_addr1, waddr_exp);
        end
    endtask

    // later stages first, so each one reads the state before this edge
    task automatic advance_model();
        if (instr_valid && x_ready) n_accept++;
        if (x_stall) n_stall++;
        if (x_btaken) n_branch++;
        m_wb_v   = m_wait_v;
        m_wb_l   = m_wait_l;
        m_wb_d   = m_wait_d;
        m_wait_v = x_we || x_load;
        m_wait_l = x_load;
        m_wait_d = x_dest;
        m_mem_v  = x_valid && !x_stall;
        m_mem_i  = m_ex_i;
        m_mem_pc = m_ex_pc;
        m_mem_e  = m_ex_e;
        if (!x_stall) begin
            m_ex_v   = m_dec_v;
            m_ex_i   = m_dec_i;
            m_ex_pc  = m_dec_pc;
            m_ex_e   = m_dec_e;
            m_dec_v  = instr_valid && x_ready && !x_btaken;
            m_dec_i  = instr;
            m_dec_pc = pc;
            m_dec_e  = m_epoch;
        end
        if (x_btaken) m_epoch = !m_epoch;
        m_start = 1'b0;
    endtask

    task automatic drive_inputs(input logic gen);
        status <= take_bits(32);
        // an offer that was not taken stays on the bus
        if (instr_valid && !x_ready) begin
            instr_valid <= 1'b1;
        end else if (gen && take_bits(2) != 0) begin
            instr_valid <= 1'b1;
            instr       <= make_instr();
            pc          <= next_pc;
            next_pc     = next_pc + 1'b1;
        end else begin
            instr_valid <= 1'b0;
        end
    endtask

    task automatic step(input logic gen);
        @(negedge clk);
        eval_model();
        compare_outputs();
        @(posedge clk);
        advance_model();
        drive_inputs(gen);
    endtask

    function automatic logic model_empty();
        return !(m_dec_v || m_ex_v || m_mem_v || m_wait_v || m_wb_v || instr_valid);
    endfunction

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        status      = '0;
        lfsr        = 32'hcf97_8709;
        next_pc     = '0;
        m_start     = 1'b1;
        m_epoch     = 1'b0;
        {m_dec_v, m_ex_v, m_mem_v, m_wait_v, m_wb_v} = '0;
        {n_checks, n_errors, n_accept, n_stall, n_branch, n_load} = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < N_CYCLES; i++) begin
            step(1'b1);
        end
        waited = 0;
        while (!model_empty() && waited < DRAIN_LIMIT) begin
            step(1'b0);
            waited++;
        end
        if (!model_empty()) begin
            n_errors++;
            $display("pipeline still busy %0d cycles after the last instruction", waited);
        end
        $display("checks %0d, errors %0d, accepted %0d, stalls %0d, branches %0d, loads %0d",
                 n_checks, n_errors, n_accept, n_stall, n_branch, n_load);
        if (n_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
